/* rtl/isa_pkg.sv */
// instruction set of the stack processor
// word and address widths with their types
// opcode encodings, the call bit and Boolean constants
// alu operation codes
`default_nettype none

package isa_pkg;

    localparam int DATA_SZ  = 16;                       // bits per word
    localparam int ADDR_SZ  = 10;                       // bits per program address
    localparam int CALL_BIT = 15;                       // set means call to low address bits

    typedef logic [DATA_SZ-1:0] word_t;
    typedef logic [ADDR_SZ-1:0] addr_t;

    localparam word_t W_TRUE  = '1;                     // Boolean true is -1
    localparam word_t W_FALSE = '0;

    typedef enum logic [15:0] {
        UC_NOP    = 16'h0000,                           // ( -- )
        UC_ADD    = 16'h0001,                           // ( a b -- a+b )
        UC_AND    = 16'h0002,                           // ( a b -- a&b )
        UC_XOR    = 16'h0003,                           // ( a b -- a^b )
        UC_ROL    = 16'h0004,                           // ( a -- a rotated left )
        UC_INC    = 16'h0005,                           // ( a -- a+1 )
        UC_FETCH  = 16'h0006,                           // ( addr -- cell )
        UC_STORE  = 16'h0007,                           // ( cell addr -- )
        UC_DUP    = 16'h0008,                           // ( a -- a a )
        UC_DROP   = 16'h0009,                           // ( a -- )
        UC_SWAP   = 16'h000A,                           // ( a b -- b a )
        UC_SKZ    = 16'h000B,                           // ( cond -- ) skip next if zero
        UC_PUSH_R = 16'h000C,                           // ( a -- ) R:( -- a )
        UC_R_DROP = 16'h000D,                           // ( -- a ) R:( a -- )
        UC_EXTN   = 16'h000E,                           // ( extn -- ) and halt
        UC_EXIT   = 16'h000F,                           // R:( addr -- ) addr->pc
        UC_LIT    = 16'h0020,                           // ( -- item ) item follows opcode
        UC_SUB    = 16'h0021,                           // ( a b -- a-b )
        UC_OR     = 16'h0022,                           // ( a b -- a|b )
        UC_NOT    = 16'h0023,                           // ( a -- ~a )
        UC_NEG    = 16'h0024,                           // ( a -- -a )
        UC_DEC    = 16'h0025,                           // ( a -- a-1 )
        UC_OVER   = 16'h002A,                           // ( a b -- a b a )
        UC_TX_OK  = 16'h003E,                           // ( -- ready )
        UC_SET_TX = 16'h003F                            // ( char -- )
    } uc_op_e;

    typedef enum logic [2:0] {
        ALU_NONE,                                       // result register holds
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_ROL
    } alu_op_e;

endpackage

`default_nettype wire

/* rtl/cpu_bus_pkg.sv */
// bundles passed between the processor blocks
// stack command carried in a class so each stack sets its payload type
// program load request, memory command and alu request
`default_nettype none

package cpu_bus_pkg;

    import isa_pkg::*;

    virtual class stk_cmd_t #(type T = logic);
        typedef struct packed {
            logic push;                                 // push and pop together replace top
            logic pop;
            logic swap;                                 // exchange the top two entries
            T     value;
        } t;
    endclass

    typedef struct packed {
        addr_t addr;
        word_t data;
    } load_req_t;

    typedef struct packed {
        logic  wr;
        addr_t waddr;
        word_t wdata;
        addr_t raddr;                                   // data appears one cycle later
    } mem_cmd_t;

    typedef struct packed {
        alu_op_e op;
        word_t   arg0;
        word_t   arg1;
    } alu_req_t;

endpackage

`default_nettype wire

/* rtl/lifo.sv */
// register-array stack shared by the data and return stacks
// push, pop, replace top and swap of the top two entries
// top two entries visible combinationally
`default_nettype none

module lifo
    import cpu_bus_pkg::*;
#(
    parameter int  DEPTH = 16,
    parameter type T     = logic
) (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  stk_cmd_t#(T)::t i_cmd,
    output T                o_s0,                       // top of stack
    output T                o_s1                        // entry below top
);

    localparam int IW = $clog2(DEPTH);

    T              mem [DEPTH];
    logic [IW:0]   cnt;                                 // entries held, one extra bit for full
    logic [IW-1:0] new_idx;                             // slot a plain push fills
    logic [IW-1:0] top_idx;
    logic [IW-1:0] sec_idx;

    assign new_idx = cnt[IW-1:0];
    assign top_idx = new_idx - 1'b1;
    assign sec_idx = new_idx - 2'd2;
    assign o_s0    = mem[top_idx];
    assign o_s1    = mem[sec_idx];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt <= '0;
        end else if (i_cmd.push && !i_cmd.pop) begin
            cnt <= cnt + 1'b1;
        end else if (i_cmd.pop && !i_cmd.push) begin
            cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_cmd.push) begin
            mem[i_cmd.pop ? top_idx : new_idx] <= i_cmd.value;
        end else if (i_cmd.swap) begin
            mem[top_idx] <= mem[sec_idx];
            mem[sec_idx] <= mem[top_idx];
        end
    end

    // the engine never pops past the bottom nor pushes past the top
    a_no_underflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_cmd.pop |-> cnt != '0);
    a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_cmd.push && !i_cmd.pop) |-> cnt != DEPTH);

endmodule

`default_nettype wire

/* rtl/alu.sv */
// registered arithmetic and logic unit
// add, subtract, and, or, xor and rotate left by one
// result holds while no operation is requested
`default_nettype none

module alu
    import isa_pkg::*;
    import cpu_bus_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  alu_req_t i_req,
    output word_t    o_data
);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_data <= '0;
        end else begin
            case (i_req.op)
                ALU_ADD: o_data <= i_req.arg0 + i_req.arg1;
                ALU_SUB: o_data <= i_req.arg0 - i_req.arg1;
                ALU_AND: o_data <= i_req.arg0 & i_req.arg1;
                ALU_OR:  o_data <= i_req.arg0 | i_req.arg1;
                ALU_XOR: o_data <= i_req.arg0 ^ i_req.arg1;
                ALU_ROL: o_data <= {i_req.arg0[DATA_SZ-2:0], i_req.arg0[DATA_SZ-1]};
                default: begin
                    // none: keep result for the write-back read
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/ucode_mem.sv */
// program memory, block ram style with registered read
// engine port for fetch, literal, fetch and store
// external load port with a four-phase req/ack handshake
`default_nettype none

module ucode_mem
    import isa_pkg::*;
    import cpu_bus_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  mem_cmd_t  i_cmd,
    output word_t     o_rdata,
    input  logic      i_load_req,
    input  load_req_t i_load,
    output logic      o_load_ack,
    input  logic      i_running
);

    localparam int MEM_WORDS = 1 << ADDR_SZ;

    word_t mem [MEM_WORDS];
    logic  ld_written;                                  // current request already stored
    logic  ld_we;

    // loads only while stopped, engine write wins
    assign ld_we = i_load_req && !ld_written && !i_running && !i_cmd.wr;

    always_ff @(posedge i_clk) begin
        if (i_cmd.wr) begin
            mem[i_cmd.waddr] <= i_cmd.wdata;
        end else if (ld_we) begin
            mem[i_load.addr] <= i_load.data;
        end
        o_rdata <= mem[i_cmd.raddr];                    // read first on same address
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ld_written <= 1'b0;
            o_load_ack <= 1'b0;
        end else begin
            if (ld_we) begin
                ld_written <= 1'b1;
            end else if (!i_load_req) begin
                ld_written <= 1'b0;                     // request withdrawn
            end
            o_load_ack <= ld_written && i_load_req;     // ack a cycle after the write
        end
    end

    a_load_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_load_req && !o_load_ack) ##1 (i_load_req && !o_load_ack) |-> $stable(i_load));

endmodule

`default_nettype wire

/* rtl/exec_engine.sv */
// execution engine of the stack processor
// four-phase fetch, decode, execute and write-back FSM
// drives both stacks, the alu and program memory
// call, exit, skip, halt and illegal opcode handling
// transmit channel with a four-phase req/ack handshake
`default_nettype none

module exec_engine
    import isa_pkg::*;
    import cpu_bus_pkg::*;
#(
    parameter int STACK_DEPTH = 16
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_run,
    output logic                 o_running,
    output logic                 o_status,
    output mem_cmd_t             o_mem,
    input  word_t                i_rdata,
    output stk_cmd_t#(word_t)::t o_d_cmd,
    input  word_t                i_d0,
    input  word_t                i_d1,
    output stk_cmd_t#(addr_t)::t o_r_cmd,
    input  addr_t                i_r0,
    output alu_req_t             o_alu,
    input  word_t                i_alu_data,
    output logic                 o_tx_req,
    output logic [7:0]           o_tx_char,
    input  logic                 i_tx_ack
);

    typedef enum logic [1:0] {PH_FETCH, PH_DECODE, PH_EXEC, PH_WBACK} phase_e;

    phase_e   phase;
    addr_t    pc;
    word_t    opcode;                                   // latched in decode
    logic     halt;
    logic     alu_wb;                                   // write-back replaces top with alu result
    logic     tx_acked;                                 // ack seen, waiting for it to fall
    logic     tx_busy;
    alu_req_t alu_nxt;

    if (STACK_DEPTH < 4 || (STACK_DEPTH & (STACK_DEPTH - 1)) != 0) begin : g_depth_check
        $error("stack depth must be a power of two from 4 upward");
    end

    // binary ops take ( a b ) as arg0 = a, arg1 = b
    function automatic alu_req_t alu_decode(word_t op, word_t d0, word_t d1);
        alu_req_t r;
        r = '{op: ALU_NONE, arg0: d1, arg1: d0};
        case (op)
            UC_ADD:  r.op = ALU_ADD;
            UC_SUB:  r.op = ALU_SUB;
            UC_AND:  r.op = ALU_AND;
            UC_OR:   r.op = ALU_OR;
            UC_XOR:  r.op = ALU_XOR;
            UC_ROL:  r = '{op: ALU_ROL, arg0: d0, arg1: d0};
            UC_INC:  r = '{op: ALU_ADD, arg0: d0, arg1: word_t'(1)};
            UC_DEC:  r = '{op: ALU_SUB, arg0: d0, arg1: word_t'(1)};
            UC_NOT:  r = '{op: ALU_XOR, arg0: d0, arg1: W_TRUE};
            UC_NEG:  r = '{op: ALU_SUB, arg0: W_FALSE, arg1: d0};
            default: r.op = ALU_NONE;
        endcase
        return r;
    endfunction

    assign alu_nxt   = alu_decode(i_rdata, i_d0, i_d1);
    assign tx_busy   = o_tx_req || tx_acked;
    assign o_running = i_run && o_status && !halt;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase     <= PH_FETCH;
            pc        <= '0;
            opcode    <= '0;
            halt      <= 1'b0;
            o_status  <= 1'b1;
            alu_wb    <= 1'b0;
            tx_acked  <= 1'b0;
            o_tx_req  <= 1'b0;
            o_tx_char <= '0;
            o_mem     <= '0;
            o_d_cmd   <= '0;
            o_r_cmd   <= '0;
            o_alu     <= '0;
        end else begin
            o_mem.wr     <= 1'b0;                       // commands last one cycle
            o_d_cmd.push <= 1'b0;
            o_d_cmd.pop  <= 1'b0;
            o_d_cmd.swap <= 1'b0;
            o_r_cmd.push <= 1'b0;
            o_r_cmd.pop  <= 1'b0;
            o_r_cmd.swap <= 1'b0;
            o_alu.op     <= ALU_NONE;
            case (phase)
                PH_FETCH: begin
                    if (o_running) begin                // rdata valid next cycle
                        phase <= PH_DECODE;
                        pc    <= pc + 1'b1;
                    end
                end
                PH_DECODE: begin
                    phase  <= PH_EXEC;
                    opcode <= i_rdata;
                    o_alu  <= alu_nxt;
                    alu_wb <= (alu_nxt.op != ALU_NONE);
                    case (i_rdata)
                        UC_ADD, UC_SUB, UC_AND, UC_OR, UC_XOR: begin
                            o_d_cmd.pop <= 1'b1;        // second operand goes now
                        end
                        UC_FETCH: o_mem.raddr <= i_d0[ADDR_SZ-1:0];
                        UC_LIT:   o_mem.raddr <= pc;    // literal sits after opcode
                        UC_STORE: begin
                            o_mem.wr    <= 1'b1;
                            o_mem.waddr <= i_d0[ADDR_SZ-1:0];
                            o_mem.wdata <= i_d1;
                            o_d_cmd.pop <= 1'b1;        // address, cell goes in execute
                        end
                        default: begin
                        end
                    endcase
                end
                PH_EXEC: begin
                    phase <= PH_WBACK;
                    case (opcode)
                        UC_NOP, UC_ADD, UC_AND, UC_XOR, UC_ROL, UC_INC, UC_FETCH,
                        UC_SUB, UC_OR, UC_NOT, UC_NEG, UC_DEC: begin
                            // finished in decode or write-back
                        end
                        UC_STORE, UC_DROP: o_d_cmd.pop <= 1'b1;
                        UC_SWAP:           o_d_cmd.swap <= 1'b1;
                        UC_LIT:            pc <= pc + 1'b1;
                        UC_DUP: begin
                            o_d_cmd.value <= i_d0;
                            o_d_cmd.push  <= 1'b1;
                        end
                        UC_OVER: begin
                            o_d_cmd.value <= i_d1;
                            o_d_cmd.push  <= 1'b1;
                        end
                        UC_SKZ: begin
                            o_d_cmd.pop <= 1'b1;
                            if (i_d0 == W_FALSE) begin
                                pc <= pc + 1'b1;        // skip the next word
                            end
                        end
                        UC_PUSH_R: begin
                            o_r_cmd.value <= i_d0[ADDR_SZ-1:0];
                            o_r_cmd.push  <= 1'b1;
                            o_d_cmd.pop   <= 1'b1;
                        end
                        UC_R_DROP: begin
                            o_d_cmd.value <= word_t'(i_r0);
                            o_d_cmd.push  <= 1'b1;
                            o_r_cmd.pop   <= 1'b1;
                        end
                        UC_EXIT: begin
                            pc          <= i_r0;
                            o_r_cmd.pop <= 1'b1;
                        end
                        UC_EXTN: begin
                            o_d_cmd.pop <= 1'b1;        // extension code consumed
                            halt        <= 1'b1;
                        end
                        UC_TX_OK: begin
                            o_d_cmd.value <= tx_busy ? W_FALSE : W_TRUE;
                            o_d_cmd.push  <= 1'b1;
                        end
                        UC_SET_TX: begin
                            phase <= PH_EXEC;           // stall until handshake ends
                            if (!tx_busy) begin
                                o_tx_req  <= 1'b1;
                                o_tx_char <= i_d0[7:0];
                            end else if (o_tx_req && i_tx_ack) begin
                                o_tx_req <= 1'b0;
                                tx_acked <= 1'b1;
                            end else if (tx_acked && !i_tx_ack) begin
                                tx_acked    <= 1'b0;
                                o_d_cmd.pop <= 1'b1;
                                phase       <= PH_WBACK;
                            end
                        end
                        default: begin
                            if (opcode[CALL_BIT]) begin
                                o_r_cmd.value <= pc;    // return to word after call
                                o_r_cmd.push  <= 1'b1;
                                pc            <= opcode[ADDR_SZ-1:0];
                            end else begin
                                o_status <= 1'b0;       // illegal instruction
                            end
                        end
                    endcase
                end
                PH_WBACK: begin
                    phase       <= PH_FETCH;
                    o_mem.raddr <= pc;                  // next instruction
                    if (alu_wb) begin
                        o_d_cmd.value <= i_alu_data;
                        o_d_cmd.pop   <= 1'b1;
                        o_d_cmd.push  <= 1'b1;
                    end else if (opcode == UC_FETCH) begin
                        o_d_cmd.value <= i_rdata;
                        o_d_cmd.pop   <= 1'b1;          // cell replaces the address
                        o_d_cmd.push  <= 1'b1;
                    end else if (opcode == UC_LIT) begin
                        o_d_cmd.value <= i_rdata;
                        o_d_cmd.push  <= 1'b1;
                    end
                end
                default: o_status <= 1'b0;              // phase error
            endcase
        end
    end

    a_tx_char_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_tx_req && $past(o_tx_req) |-> $stable(o_tx_char));

endmodule

`default_nettype wire

/* rtl/ucode_cpu.sv */
// top level of the microcoded stack processor
// engine, program memory, alu, data stack and return stack
`default_nettype none

module ucode_cpu
    import isa_pkg::*;
    import cpu_bus_pkg::*;
#(
    parameter int STACK_DEPTH = 16
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_run,
    input  logic       i_load_req,
    input  load_req_t  i_load,
    output logic       o_load_ack,
    output logic       o_running,
    output logic       o_status,
    output logic       o_tx_req,
    output logic [7:0] o_tx_char,
    input  logic       i_tx_ack
);

    mem_cmd_t             mem_cmd;
    word_t                mem_rdata;
    stk_cmd_t#(word_t)::t d_cmd;
    stk_cmd_t#(addr_t)::t r_cmd;
    word_t                d0;
    word_t                d1;
    addr_t                r0;
    alu_req_t             alu_req;
    word_t                alu_data;

    exec_engine #(
        .STACK_DEPTH(STACK_DEPTH)
    ) engine_inst (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_run      (i_run),
        .o_running  (o_running),
        .o_status   (o_status),
        .o_mem      (mem_cmd),
        .i_rdata    (mem_rdata),
        .o_d_cmd    (d_cmd),
        .i_d0       (d0),
        .i_d1       (d1),
        .o_r_cmd    (r_cmd),
        .i_r0       (r0),
        .o_alu      (alu_req),
        .i_alu_data (alu_data),
        .o_tx_req   (o_tx_req),
        .o_tx_char  (o_tx_char),
        .i_tx_ack   (i_tx_ack)
    );

    ucode_mem mem_inst (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_cmd      (mem_cmd),
        .o_rdata    (mem_rdata),
        .i_load_req (i_load_req),
        .i_load     (i_load),
        .o_load_ack (o_load_ack),
        .i_running  (o_running)
    );

    alu alu_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_req   (alu_req),
        .o_data  (alu_data)
    );

    lifo #(.DEPTH(STACK_DEPTH), .T(word_t)) d_stack (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_cmd   (d_cmd),
        .o_s0    (d0),
        .o_s1    (d1)
    );

    // return stack, only its top is read
    lifo #(.DEPTH(STACK_DEPTH), .T(addr_t)) r_stack (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_cmd   (r_cmd),
        .o_s0    (r0),
        .o_s1    ()
    );

endmodule

`default_nettype wire

/* dv/cpu_checker.sv */
// checker for the stack processor testbench
// compares each transmitted character with a queue of expected ones
// checks the final status when the processor stops
// reports missing and extra characters
`default_nettype none

module cpu_checker (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_running,
    input  logic       i_status,
    input  logic       i_tx_req,
    input  logic [7:0] i_tx_char
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0] exp_chars [$];                          // characters still to come
    logic [7:0] exp_char;
    logic       exp_status = 1'b1;
    logic       prev_req;
    logic       prev_running;
    int         err_cnt    = 0;
    int         chars_seen = 0;

    task automatic expect_char(input logic [7:0] c);
        exp_chars.push_back(c);
    endtask

    task automatic expect_status(input logic s);
        exp_status = s;
    endtask

    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            prev_req     = 1'b0;
            prev_running = 1'b0;
        end else begin
            if (i_tx_req && !prev_req) begin            // new transfer starts
                if (exp_chars.size() == 0) begin
                    err_cnt++;
                    $display("at %0t character %h was sent with none expected",
                             $time, i_tx_char);
                end else begin
                    exp_char = exp_chars.pop_front();
                    chars_seen++;
                    if (i_tx_char !== exp_char) begin
                        err_cnt++;
                        $display("** Error at %0t: o_tx_char = %h, expected %h",
                                 $time, i_tx_char, exp_char);
                    end
                end
            end
            if (prev_running && !i_running) begin       // halt or illegal opcode
                if (i_status !== exp_status) begin
                    err_cnt++;
                    $display("** Error at %0t: o_status = %b, expected %b",
                             $time, i_status, exp_status);
                end
                if (exp_chars.size() != 0) begin
                    err_cnt++;
                    $display("at %0t the run stopped with %0d expected characters never sent",
                             $time, exp_chars.size());
                    exp_chars.delete();
                end
            end
            prev_req     = i_tx_req;
            prev_running = i_running;
        end
    end

endmodule

`default_nettype wire

/* dv/tb_ucode_cpu.sv */
// testbench top for the microcoded stack processor
// clock, reset, stimulus file parsing and program loading
// run control, transmit acknowledge with random delay
// cycle limit worked out from the stimulus file
`default_nettype none

module tb_ucode_cpu
    import isa_pkg::*;
    import cpu_bus_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic       i_clk;
    logic       i_rst_n;
    logic       i_run;
    logic       i_load_req;
    load_req_t  i_load;
    logic       o_load_ack;
    logic       o_running;
    logic       o_status;
    logic       o_tx_req;
    logic [7:0] o_tx_char;
    logic       i_tx_ack;

    int              fd;
    int              code;
    int              errors;
    int              max_delay;                         // ack delay bound in cycles
    int              delay;
    int              seed;
    int              cycles = 0;
    int              limit  = 0;
    logic [7:0]      kind;                              // first character of a stimulus line
    logic [15:0]     val_a;
    logic [15:0]     val_b;
    logic            fresh;                             // next load starts a new program
    reg [8*160-1:0]  line;

    ucode_cpu #(
        .STACK_DEPTH(16)
    ) ucode_cpu_inst (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_run      (i_run),
        .i_load_req (i_load_req),
        .i_load     (i_load),
        .o_load_ack (o_load_ack),
        .o_running  (o_running),
        .o_status   (o_status),
        .o_tx_req   (o_tx_req),
        .o_tx_char  (o_tx_char),
        .i_tx_ack   (i_tx_ack)
    );

    cpu_checker checker_inst (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_running (o_running),
        .i_status  (o_status),
        .i_tx_req  (o_tx_req),
        .i_tx_char (o_tx_char)
    );

    initial i_clk = 1'b0;
    always #5 i_clk = ~i_clk;                           // 10 ns period

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            errors++;
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, want);
        end
    endtask

    // 60 cycles per word, plus the ack bound, plus 4 per expected character
    task automatic compute_limit();
        int          lfd;
        int          rc;
        logic [7:0]  k;
        logic [15:0] v;
        lfd = $fopen("dv/cpu_input.txt", "r");
        while (lfd != 0 && !$feof(lfd)) begin
            rc = $fscanf(lfd, " %c", k);
            if (rc == 1) begin
                rc = $fgets(line, lfd);                 // rest of the line
                if (k == "P") limit += 60;
                if (k == "E") limit += 4;
                if (k == "D") begin
                    rc = $sscanf(line, "%h", v);
                    limit += int'(v);
                end
            end
        end
        if (lfd != 0) $fclose(lfd);
    endtask

    task automatic apply_reset();
        @(negedge i_clk);
        i_rst_n    = 1'b0;
        i_run      = 1'b0;
        i_load_req = 1'b0;
        repeat (16) @(negedge i_clk);
        i_rst_n = 1'b1;
        @(negedge i_clk);
        check_bit("o_running", o_running, 1'b0);
        check_bit("o_tx_req", o_tx_req, 1'b0);
        check_bit("o_load_ack", o_load_ack, 1'b0);
        check_bit("o_status", o_status, 1'b1);
    endtask

    task automatic load_word(input logic [15:0] addr, input logic [15:0] data);
        int waited;
        i_load.addr = addr[ADDR_SZ-1:0];
        i_load.data = data;
        i_load_req  = 1'b1;
        waited      = 0;
        do begin
            @(negedge i_clk);
            waited++;
        end while (!o_load_ack);
        if (waited != 2) begin
            errors++;
            $display("load at %h was acknowledged after %0d cycles, not 2", addr, waited);
        end
        i_load_req = 1'b0;
        @(negedge i_clk);
        check_bit("o_load_ack", o_load_ack, 1'b0);      // ack falls a cycle after req
    endtask

    task automatic run_program();
        i_run = 1'b1;
        @(negedge i_clk);
        check_bit("o_running", o_running, 1'b1);
        while (o_running) begin
            @(negedge i_clk);
        end
        repeat (4) @(negedge i_clk);                    // let the checker see the stop
        i_run = 1'b0;
        @(negedge i_clk);
    endtask

    // four-phase acknowledge for the transmit channel
    always begin
        @(negedge i_clk);
        if (o_tx_req && !i_tx_ack) begin
            delay = $unsigned($random(seed)) % (max_delay + 1);
            repeat (delay) @(negedge i_clk);
            i_tx_ack = 1'b1;
            do begin
                @(negedge i_clk);
            end while (o_tx_req);
            i_tx_ack = 1'b0;
        end
    end

    always @(posedge i_clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("timeout after %0d cycles, the programs did not finish", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        i_rst_n    = 1'b0;
        i_run      = 1'b0;
        i_load_req = 1'b0;
        i_load     = '0;
        i_tx_ack   = 1'b0;
        errors     = 0;
        max_delay  = 0;
        seed       = 32'h38b3;
        fresh      = 1'b1;
        compute_limit();
        fd = $fopen("dv/cpu_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file dv/cpu_input.txt");
            $display("TEST FAILED");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, " %c", kind);
                if (code == 1) begin
                    case (kind)
                        "#": code = $fgets(line, fd);   // comment line
                        "P": begin
                            code = $fscanf(fd, "%h %h", val_a, val_b);
                            if (fresh) begin
                                apply_reset();
                                fresh = 1'b0;
                            end
                            load_word(val_a, val_b);
                        end
                        "E": begin
                            code = $fscanf(fd, "%h", val_a);
                            checker_inst.expect_char(val_a[7:0]);
                        end
                        "S": begin
                            code = $fscanf(fd, "%h", val_a);
                            checker_inst.expect_status(val_a[0]);
                        end
                        "D": begin
                            code      = $fscanf(fd, "%h", val_a);
                            max_delay = int'(val_a);
                        end
                        "G": begin
                            run_program();
                            fresh = 1'b1;
                        end
                        default: begin
                            errors++;
                            $display("unknown line kind %c in the stimulus file", kind);
                        end
                    endcase
                end
            end
            $fclose(fd);
            repeat (4) @(negedge i_clk);
            $display("errors: testbench %0d, checker %0d, characters checked %0d",
                     errors, checker_inst.err_cnt, checker_inst.chars_seen);
            if (errors + checker_inst.err_cnt == 0) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* dv/cpu_input.txt */
# P addr word = program load, E char = expected transmit, S bit = final status
# D n = max ack delay in cycles, G = run; all numbers hex, reset before each program
# arithmetic and logic
D 2
P 000 0020
P 001 1234
P 002 0020
P 003 0011
P 004 0001
P 005 0008
P 006 003F
P 007 0020
P 008 0245
P 009 0021
P 00A 0008
P 00B 003F
P 00C 0020
P 00D 0F0F
P 00E 0022
P 00F 0008
P 010 003F
P 011 0020
P 012 00F3
P 013 0002
P 014 0020
P 015 00A5
P 016 0003
P 017 0008
P 018 003F
P 019 0023
P 01A 0008
P 01B 003F
P 01C 0024
P 01D 0008
P 01E 003F
P 01F 0005
P 020 0008
P 021 003F
P 022 0020
P 023 8081
P 024 0004
P 025 003F
P 026 0025
P 027 003F
P 028 0020
P 029 0000
P 02A 000E
E 45
E 00
E 0F
E A6
E 59
E A7
E A8
E 03
E A7
S 1
G
# stack, return stack and memory
P 000 0020
P 001 0011
P 002 0020
P 003 0022
P 004 000A
P 005 003F
P 006 0020
P 007 0033
P 008 002A
P 009 003F
P 00A 0008
P 00B 0009
P 00C 003F
P 00D 0020
P 00E 0144
P 00F 000C
P 010 0020
P 011 0066
P 012 003F
P 013 000D
P 014 003F
P 015 0020
P 016 7788
P 017 0020
P 018 0300
P 019 0007
P 01A 0020
P 01B 0300
P 01C 0006
P 01D 003F
P 01E 000E
E 11
E 22
E 33
E 66
E 44
E 88
S 1
G
# call, exit and skip on zero
P 000 0020
P 001 0041
P 002 8010
P 003 0020
P 004 0000
P 005 000B
P 006 8020
P 007 0020
P 008 0001
P 009 000B
P 00A 8020
P 00B 0020
P 00C 0000
P 00D 000E
P 010 003F
P 011 000F
P 020 0020
P 021 0058
P 022 003F
P 023 000F
E 41
E 58
S 1
G
# transmit back-pressure with tx ready checks
D 6
P 000 0020
P 001 0031
P 002 003E
P 003 003F
P 004 003F
P 005 003E
P 006 003F
P 007 0020
P 008 0032
P 009 003F
P 00A 0020
P 00B 0000
P 00C 000E
E FF
E 31
E FF
E 32
S 1
G
# illegal opcode stops the processor
D 1
P 000 0020
P 001 0061
P 002 003F
P 003 0010
P 004 0020
P 005 0062
P 006 003F
P 007 0020
P 008 0000
P 009 000E
E 61
S 0
G

/* tb.f */
rtl/isa_pkg.sv
rtl/cpu_bus_pkg.sv
rtl/lifo.sv
rtl/alu.sv
rtl/ucode_mem.sv
rtl/exec_engine.sv
rtl/ucode_cpu.sv
dv/cpu_checker.sv
dv/tb_ucode_cpu.sv

/* Makefile */
# Verilator build and run of the stack processor testbench

TOP := tb_ucode_cpu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TEST OK" sim.log || (echo "no verdict in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
